/* include/upsp_consts.svh */
`ifndef UPSP_CONSTS_SVH
`define UPSP_CONSTS_SVH

// Pixel width on both streams
`define UPSP_PIX_W 16

// Source frame, destination is 2x in both directions
`define UPSP_SRC_W 4
`define UPSP_SRC_H 2
`define UPSP_DST_W (2 * `UPSP_SRC_W)
`define UPSP_DST_H (2 * `UPSP_SRC_H)

// Input FIFO entries
`define UPSP_FIFO_DEPTH 4

// Register map on the 2-bit register address
`define UPSP_ADDR_UPSTR  2'd0
`define UPSP_ADDR_UPENDR 2'd1

`endif

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module upsp_tb \
	-f sim.f -o upsp_sim > "$LOG" 2>&1 &&
	./obj_dir/upsp_sim >> "$LOG" 2>&1 ||
	echo "Build or run stopped with an error" >> "$LOG"
cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1
grep -q "Simulation completed successfully" "$LOG" || exit 1
exit 0

/* sim.f */
+incdir+include
source/upsp_pkg.sv
source/crf_write_arbiter.sv
source/config_regfile.sv
source/stream_in.sv
source/upsampler.sv
source/access_control.sv
source/upsp_top.sv
verif/upsp_checker.sv
verif/upsp_properties.sv
verif/upsp_tb.sv

/* source/access_control.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module access_control import upsp_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   upstr,
	input  logic                   upendr,
	input  logic                   wrt,
	input  logic [`UPSP_PIX_W-1:0] wdata,
	output logic                   wready,
	output axis_beat_t             m_axis,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready,
	output crf_req_t               ac_req,
	input  logic                   ac_grant
);

	localparam int IW = $clog2(`UPSP_DST_W);
	localparam int TOTAL = `UPSP_DST_W * `UPSP_DST_H;
	localparam int PW = $clog2(TOTAL);
	localparam logic [IW-1:0] IDX_LAST = IW'(`UPSP_DST_W - 1);
	localparam logic [PW-1:0] PIX_LAST = PW'(TOTAL - 1);

	logic [`UPSP_PIX_W-1:0] buf_mem [2][`UPSP_DST_W];
	logic [1:0]             buf_full;
	logic                   wr_sel;
	logic                   rd_sel;
	logic [IW-1:0]          wr_idx;
	logic [IW-1:0]          rd_idx;
	logic [PW-1:0]          pix_cnt;
	ac_status_e             ac_st;
	logic                   wr_fire;
	logic                   load;
	logic                   last_fire;
	logic                   restart;

	// Room left in at least one row buffer
	assign wready    = ~(&buf_full);
	assign wr_fire   = wrt & wready;
	assign load      = buf_full[rd_sel] & (ac_st == ac_run) & (~m_axis_tvalid | m_axis_tready);
	assign last_fire = m_axis_tvalid & m_axis_tready & m_axis.tlast;
	assign restart   = (ac_st == ac_wait_restart) & upstr & ~upendr;

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			buf_mem[wr_sel][wr_idx] <= wdata;
		end
		if (load) begin
			m_axis.tdata <= buf_mem[rd_sel][rd_idx];
			m_axis.tlast <= (pix_cnt == PIX_LAST);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_full      <= 2'b00;
			wr_sel        <= 1'b0;
			rd_sel        <= 1'b0;
			wr_idx        <= '0;
			rd_idx        <= '0;
			pix_cnt       <= '0;
			m_axis_tvalid <= 1'b0;
		end else if (restart) begin
			buf_full <= 2'b00;
			wr_sel   <= 1'b0;
			rd_sel   <= 1'b0;
			wr_idx   <= '0;
			rd_idx   <= '0;
			pix_cnt  <= '0;
		end else begin
			// Fill side, a full row hands the buffer to the reader
			if (wr_fire) begin
				wr_idx <= wr_idx + 1'b1;
				if (wr_idx == IDX_LAST) begin
					wr_idx           <= '0;
					buf_full[wr_sel] <= 1'b1;
					wr_sel           <= ~wr_sel;
				end
			end
			// Drain side, rows leave in the order they were written
			if (load) begin
				pix_cnt <= pix_cnt + 1'b1;
				rd_idx  <= rd_idx + 1'b1;
				if (rd_idx == IDX_LAST) begin
					rd_idx           <= '0;
					buf_full[rd_sel] <= 1'b0;
					rd_sel           <= ~rd_sel;
				end
			end
			if (load) begin
				m_axis_tvalid <= 1'b1;
			end else if (m_axis_tready) begin
				m_axis_tvalid <= 1'b0;
			end
		end
	end

	// End of frame, clear UPSTR then set UPENDR
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac_st <= ac_run;
		end else begin
			case (ac_st)
				ac_run: begin
					if (last_fire) begin
						ac_st <= ac_clear_start;
					end
				end
				ac_clear_start: begin
					if (ac_grant) begin
						ac_st <= ac_set_done;
					end
				end
				ac_set_done: begin
					if (ac_grant) begin
						ac_st <= ac_wait_restart;
					end
				end
				ac_wait_restart: begin
					if (restart) begin
						ac_st <= ac_run;
					end
				end
				default: begin
					ac_st <= ac_run;
				end
			endcase
		end
	end

	always_comb begin
		ac_req = '0;
		case (ac_st)
			ac_clear_start: begin
				ac_req.valid = 1'b1;
				ac_req.write = 1'b1;
				ac_req.addr  = `UPSP_ADDR_UPSTR;
				ac_req.wdata = 32'd0;
			end
			ac_set_done: begin
				ac_req.valid = 1'b1;
				ac_req.write = 1'b1;
				ac_req.addr  = `UPSP_ADDR_UPENDR;
				ac_req.wdata = 32'd1;
			end
			default: begin
			end
		endcase
	end

endmodule

/* source/config_regfile.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module config_regfile import upsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  crf_req_t    crf_req,
	input  logic        host_rd_pending,
	output logic [31:0] host_rdata,
	output logic        upstr,
	output logic        upendr
);

	logic [31:0] rdata_q;

	// Flag registers, only bit 0 is kept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			upstr  <= 1'b0;
			upendr <= 1'b0;
		end else if (crf_req.valid && crf_req.write) begin
			case (crf_req.addr)
				`UPSP_ADDR_UPSTR: begin
					upstr <= crf_req.wdata[0];
				end
				`UPSP_ADDR_UPENDR: begin
					upendr <= crf_req.wdata[0];
				end
				default: begin
				end
			endcase
		end
	end

	// Read data captured at the grant edge
	always_ff @(posedge clk) begin
		if (crf_req.valid && !crf_req.write) begin
			case (crf_req.addr)
				`UPSP_ADDR_UPSTR: begin
					rdata_q <= {31'd0, upstr};
				end
				`UPSP_ADDR_UPENDR: begin
					rdata_q <= {31'd0, upendr};
				end
				default: begin
					rdata_q <= '0;
				end
			endcase
		end
	end

	assign host_rdata = host_rd_pending ? rdata_q : 32'd0;

endmodule

/* source/crf_write_arbiter.sv */
`timescale 1ns/1ps

module crf_write_arbiter import upsp_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  crf_req_t ac_req,
	input  crf_req_t host_req,
	output logic     ac_grant,
	output logic     host_grant,
	output crf_req_t crf_req,
	output logic     host_rd_pending
);

	// Access control always wins, host gets the leftover cycles
	assign ac_grant   = ac_req.valid;
	assign host_grant = host_req.valid & ~ac_req.valid;

	always_comb begin
		if (ac_grant) begin
			crf_req = ac_req;
		end else if (host_grant) begin
			crf_req = host_req;
		end else begin
			crf_req = '0;
		end
	end

	// Marks the cycle in which host read data is returned
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			host_rd_pending <= 1'b0;
		end else begin
			host_rd_pending <= host_grant & ~host_req.write;
		end
	end

endmodule

/* source/stream_in.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module stream_in import upsp_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   upstr,
	input  logic                   upendr,
	input  axis_beat_t             s_axis,
	input  logic                   s_axis_tvalid,
	output logic                   s_axis_tready,
	input  logic                   rd,
	output logic                   rvalid,
	output logic [`UPSP_PIX_W-1:0] rdata
);

	localparam int PTR_W = $clog2(`UPSP_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`UPSP_FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`UPSP_FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`UPSP_FIFO_DEPTH);

	axis_beat_t       fifo_mem [`UPSP_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign s_axis_tready = upstr & ~upendr & (count != CNT_FULL);
	assign rvalid        = (count != '0);
	assign rdata         = fifo_mem[rd_ptr].tdata;

	assign push = s_axis_tvalid & s_axis_tready;
	assign pop  = rd & rvalid;

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= s_axis;
		end
	end

	// Pointers wrap at the depth, flushed once the frame is done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (upendr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* source/upsampler.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module upsampler import upsp_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   upstr,
	input  logic                   upendr,
	input  logic                   rvalid,
	input  logic [`UPSP_PIX_W-1:0] rdata,
	output logic                   rd,
	output logic                   wrt,
	output logic [`UPSP_PIX_W-1:0] wdata,
	input  logic                   wready
);

	localparam int SW = $clog2(`UPSP_SRC_W);
	localparam int CW = SW + 1;
	localparam int RW = $clog2(`UPSP_SRC_H + 1);
	localparam logic [CW-1:0] LOAD_LAST = CW'(`UPSP_SRC_W - 1);
	localparam logic [CW-1:0] COL_LAST  = CW'(`UPSP_DST_W - 1);
	localparam logic [RW-1:0] ROW_LAST  = RW'(`UPSP_SRC_H - 1);
	localparam logic [RW-1:0] ROW_END   = RW'(`UPSP_SRC_H);

	upsp_state_e            state;
	logic [`UPSP_PIX_W-1:0] row_q [`UPSP_SRC_W];
	logic [CW-1:0]          idx;
	logic                   second_row;
	logic [RW-1:0]          row_cnt;
	logic                   processing;

	assign processing = upstr & ~upendr;

	assign rd  = (state == st_load_row) & rvalid;
	assign wrt = (state == st_emit_row);
	// Each source pixel covers two destination columns
	assign wdata = row_q[idx[CW-1:1]];

	always_ff @(posedge clk) begin
		if (rd) begin
			row_q[idx[SW-1:0]] <= rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			idx        <= '0;
			second_row <= 1'b0;
			row_cnt    <= '0;
		end else if (!processing) begin
			state      <= st_idle;
			idx        <= '0;
			second_row <= 1'b0;
			row_cnt    <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (row_cnt != ROW_END) begin
						state <= st_load_row;
					end
				end
				st_load_row: begin
					if (rd) begin
						idx <= idx + 1'b1;
						if (idx == LOAD_LAST) begin
							idx   <= '0;
							state <= st_emit_row;
						end
					end
				end
				st_emit_row: begin
					if (wready) begin
						idx <= idx + 1'b1;
						if (idx == COL_LAST) begin
							idx        <= '0;
							second_row <= ~second_row;
							// Both copies of the row sent
							if (second_row) begin
								row_cnt <= row_cnt + 1'b1;
								state   <= (row_cnt == ROW_LAST) ? st_idle : st_load_row;
							end
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* source/upsp_pkg.sv */
`include "upsp_consts.svh"

package upsp_pkg;

	// One request on the register file port
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [1:0]  addr;
		logic [31:0] wdata;
	} crf_req_t;

	// Stream beat, shared by the slave and master ports
	typedef struct packed {
		logic [`UPSP_PIX_W-1:0] tdata;
		logic                   tlast;
	} axis_beat_t;

	// Up-sampler FSM
	typedef enum logic [1:0] {
		st_idle,
		st_load_row,
		st_emit_row
	} upsp_state_e;

	// Status-write FSM of the access control
	typedef enum logic [1:0] {
		ac_run,
		ac_clear_start,
		ac_set_done,
		ac_wait_restart
	} ac_status_e;

endpackage

/* source/upsp_top.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module upsp_top import upsp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  crf_req_t    host_req,
	output logic        host_grant,
	output logic [31:0] host_rdata,
	input  axis_beat_t  s_axis,
	input  logic        s_axis_tvalid,
	output logic        s_axis_tready,
	output axis_beat_t  m_axis,
	output logic        m_axis_tvalid,
	input  logic        m_axis_tready
);

	crf_req_t               ac_req;
	crf_req_t               crf_req;
	logic                   ac_grant;
	logic                   host_rd_pending;
	logic                   upstr;
	logic                   upendr;
	logic                   rd;
	logic                   rvalid;
	logic [`UPSP_PIX_W-1:0] rdata;
	logic                   wrt;
	logic [`UPSP_PIX_W-1:0] wdata;
	logic                   wready;

	crf_write_arbiter crf_write_arbiter_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.ac_req          (ac_req),
		.host_req        (host_req),
		.ac_grant        (ac_grant),
		.host_grant      (host_grant),
		.crf_req         (crf_req),
		.host_rd_pending (host_rd_pending)
	);

	config_regfile config_regfile_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.crf_req         (crf_req),
		.host_rd_pending (host_rd_pending),
		.host_rdata      (host_rdata),
		.upstr           (upstr),
		.upendr          (upendr)
	);

	stream_in stream_in_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.upstr         (upstr),
		.upendr        (upendr),
		.s_axis        (s_axis),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.rd            (rd),
		.rvalid        (rvalid),
		.rdata         (rdata)
	);

	upsampler upsampler_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.upstr  (upstr),
		.upendr (upendr),
		.rvalid (rvalid),
		.rdata  (rdata),
		.rd     (rd),
		.wrt    (wrt),
		.wdata  (wdata),
		.wready (wready)
	);

	access_control access_control_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.upstr         (upstr),
		.upendr        (upendr),
		.wrt           (wrt),
		.wdata         (wdata),
		.wready        (wready),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.ac_req        (ac_req),
		.ac_grant      (ac_grant)
	);

endmodule

/* verif/upsp_checker.sv */
`timescale 1ns/1ps

module upsp_checker import upsp_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input axis_beat_t m_axis,
	input logic       m_axis_tvalid,
	input logic       m_axis_tready
);

	axis_beat_t exp_q[$];
	string      test_name = "none";
	int         test_err  = 0;
	int         pass_cnt  = 0;
	int         fail_cnt  = 0;
	int         beat_cnt  = 0;

	task automatic push_beat(input axis_beat_t beat);
		exp_q.push_back(beat);
	endtask

	function automatic int pending_beats();
		return exp_q.size();
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_err  = 0;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
			test_err++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		test_err++;
	endtask

	task automatic end_test();
		if (test_err == 0) begin
			$display("PASS %s", test_name);
			pass_cnt++;
		end else begin
			$display("FAIL %s with %0d errors", test_name, test_err);
			fail_cnt++;
		end
	endtask

	task automatic print_counts();
		$display("Tests passed: %0d, failed: %0d, output beats checked: %0d",
			pass_cnt, fail_cnt, beat_cnt);
	endtask

	// Every output handshake is taken from the head of the model queue
	always @(negedge clk) begin
		axis_beat_t exp_beat;
		if (rst_n && m_axis_tvalid && m_axis_tready) begin
			if (exp_q.size() == 0) begin
				report_error("output beat arrived with no expected beat left");
			end else begin
				exp_beat = exp_q.pop_front();
				check_value($sformatf("beat %0d", beat_cnt), 32'(exp_beat), 32'(m_axis));
				beat_cnt++;
			end
		end
	end

endmodule

/* verif/upsp_properties.sv */
`timescale 1ns/1ps

module upsp_properties import upsp_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input axis_beat_t m_axis,
	input logic       m_axis_tvalid,
	input logic       m_axis_tready,
	input logic       s_axis_tready,
	input logic       upstr,
	input logic       upendr,
	input logic       rd,
	input logic       rvalid,
	input logic       ac_grant,
	input logic       host_grant
);

	// Output beat held while the sink stalls
	assert property (@(posedge clk) disable iff (!rst_n)
		(m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis)))
		else $error("m_axis changed while stalled");

	assert property (@(posedge clk) disable iff (!rst_n)
		!(upstr && !upendr) |-> !s_axis_tready)
		else $error("s_axis_tready high while not processing");

	assert property (@(posedge clk) disable iff (!rst_n) rd |-> rvalid)
		else $error("rd issued on an empty FIFO");

	assert property (@(posedge clk) disable iff (!rst_n) !(ac_grant && host_grant))
		else $error("both register port grants high");

endmodule

bind upsp_top upsp_properties upsp_properties_inst (
	.clk           (clk),
	.rst_n         (rst_n),
	.m_axis        (m_axis),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tready (m_axis_tready),
	.s_axis_tready (s_axis_tready),
	.upstr         (upstr),
	.upendr        (upendr),
	.rd            (rd),
	.rvalid        (rvalid),
	.ac_grant      (ac_grant),
	.host_grant    (host_grant)
);

/* verif/upsp_tb.sv */
`timescale 1ns/1ps

`include "upsp_consts.svh"

module upsp_tb import upsp_pkg::*; ();

	localparam int PIX_W       = `UPSP_PIX_W;
	localparam int SRC_N       = `UPSP_SRC_W * `UPSP_SRC_H;
	localparam int GRANT_LIMIT = 20;
	localparam int IDLE_LIMIT  = 200;
	localparam int FRAME_LIMIT = 2000;
	localparam int POLL_LIMIT  = 50;
	localparam int GATE_CYCLES = 20;
	localparam int TAIL_BEATS  = 2;

	logic             clk;
	logic             rst_n;
	crf_req_t         host_req;
	logic             host_grant;
	logic [31:0]      host_rdata;
	axis_beat_t       s_axis;
	logic             s_axis_tvalid;
	logic             s_axis_tready;
	axis_beat_t       m_axis;
	logic             m_axis_tvalid;
	logic             m_axis_tready;
	logic [PIX_W-1:0] src_pix [SRC_N];
	bit               aborted;

	upsp_top upsp_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_req      (host_req),
		.host_grant    (host_grant),
		.host_rdata    (host_rdata),
		.s_axis        (s_axis),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	upsp_checker upsp_checker_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	always #20 clk = ~clk;

	task automatic flag_timeout(input string what);
		upsp_checker_inst.report_error($sformatf("timed out waiting for %s", what));
		aborted = 1'b1;
	endtask

	// One host access with read data sampled the cycle after the grant
	task automatic host_access(input logic wr, input logic [1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		if (aborted) begin
			return;
		end
		@(posedge clk);
		#1;
		host_req.valid = 1'b1;
		host_req.write = wr;
		host_req.addr  = addr;
		host_req.wdata = data;
		@(negedge clk);
		while (!host_grant && waited < GRANT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!host_grant) begin
			flag_timeout("host_grant");
			host_req = '0;
			return;
		end
		@(posedge clk);
		#1;
		host_req = '0;
		@(negedge clk);
		rdata = host_rdata;
	endtask

	task automatic host_write(input logic [1:0] addr, input logic [31:0] data);
		logic [31:0] unused_rdata;
		host_access(1'b1, addr, data, unused_rdata);
	endtask

	task automatic host_read_check(input string what, input logic [1:0] addr,
			input logic [31:0] exp);
		logic [31:0] rdata;
		host_access(1'b0, addr, 32'd0, rdata);
		if (!aborted) begin
			upsp_checker_inst.check_value(what, exp, rdata);
		end
	endtask

	// Poll until the done flag shows and expect start to be clear by then
	task automatic poll_status();
		logic [31:0] endr;
		logic [31:0] str;
		int          polls;
		endr  = '0;
		str   = '0;
		polls = 0;
		while (endr[0] !== 1'b1 && !aborted) begin
			host_access(1'b0, `UPSP_ADDR_UPENDR, 32'd0, endr);
			host_access(1'b0, `UPSP_ADDR_UPSTR, 32'd0, str);
			if (endr[0] && str[0]) begin
				upsp_checker_inst.report_error("a poll read UPENDR and UPSTR both set");
			end
			polls++;
			if (polls > POLL_LIMIT && endr[0] !== 1'b1) begin
				flag_timeout("UPENDR to be set");
			end
		end
		if (!aborted) begin
			upsp_checker_inst.check_value("UPSTR after done", 32'd0, str);
		end
	endtask

	// Start polling once only the last few beats are still expected
	task automatic poll_near_end();
		int cycles;
		cycles = 0;
		while (upsp_checker_inst.pending_beats() > TAIL_BEATS && !aborted) begin
			@(negedge clk);
			cycles++;
			if (cycles > FRAME_LIMIT) begin
				flag_timeout("the tail of the frame");
			end
		end
		poll_status();
	endtask

	// Destination pixel (r, c) takes source pixel (r/2, c/2)
	task automatic build_frame();
		axis_beat_t beat;
		for (int i = 0; i < SRC_N; i++) begin
			src_pix[i] = PIX_W'($urandom);
		end
		for (int r = 0; r < `UPSP_DST_H; r++) begin
			for (int c = 0; c < `UPSP_DST_W; c++) begin
				beat.tdata = src_pix[(r / 2) * `UPSP_SRC_W + (c / 2)];
				beat.tlast = (r == `UPSP_DST_H - 1) && (c == `UPSP_DST_W - 1);
				upsp_checker_inst.push_beat(beat);
			end
		end
	endtask

	task automatic send_frame(input bit gaps);
		int i;
		int idle;
		bit took;
		i    = 0;
		idle = 0;
		took = 1'b0;
		while (i < SRC_N && !aborted) begin
			@(posedge clk);
			#1;
			if (took) begin
				s_axis_tvalid = 1'b0;
			end
			// A new beat only once the previous one has gone
			if (!s_axis_tvalid && (!gaps || $urandom_range(3) != 0)) begin
				s_axis_tvalid = 1'b1;
				s_axis.tdata  = src_pix[i];
				s_axis.tlast  = (i == SRC_N - 1);
			end
			@(negedge clk);
			took = s_axis_tvalid && s_axis_tready;
			if (took) begin
				i++;
				idle = 0;
			end else begin
				idle++;
				if (idle > IDLE_LIMIT) begin
					flag_timeout("s_axis_tready");
				end
			end
		end
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
	endtask

	task automatic drain_frame(input bit stall);
		int cycles;
		cycles = 0;
		while (upsp_checker_inst.pending_beats() != 0 && !aborted) begin
			@(posedge clk);
			#1;
			m_axis_tready = !stall || ($urandom_range(1) == 1);
			cycles++;
			if (cycles > FRAME_LIMIT) begin
				flag_timeout("the last output beat");
			end
		end
		m_axis_tready = 1'b1;
	endtask

	task automatic run_frame(input bit random_flow);
		build_frame();
		fork
			send_frame(random_flow);
			drain_frame(random_flow);
		join
	endtask

	task automatic restart_frame();
		host_write(`UPSP_ADDR_UPENDR, 32'd0);
		host_write(`UPSP_ADDR_UPSTR, 32'd1);
	endtask

	task automatic test_reset_state();
		upsp_checker_inst.start_test("reset_state");
		@(negedge clk);
		upsp_checker_inst.check_value("m_axis_tvalid", 32'd0, 32'(m_axis_tvalid));
		upsp_checker_inst.check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
		host_read_check("UPSTR", `UPSP_ADDR_UPSTR, 32'd0);
		host_read_check("UPENDR", `UPSP_ADDR_UPENDR, 32'd0);
		upsp_checker_inst.end_test();
	endtask

	// Offered beats must be ignored until start is written
	task automatic test_idle_gate();
		upsp_checker_inst.start_test("idle_gate");
		@(posedge clk);
		#1;
		m_axis_tready = 1'b1;
		s_axis_tvalid = 1'b1;
		s_axis.tdata  = PIX_W'($urandom);
		repeat (GATE_CYCLES) begin
			@(negedge clk);
			upsp_checker_inst.check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
			upsp_checker_inst.check_value("m_axis_tvalid", 32'd0, 32'(m_axis_tvalid));
		end
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
		upsp_checker_inst.end_test();
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		host_req      = '0;
		s_axis        = '0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		aborted       = 1'b0;
		void'($urandom(32'h1f21));
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset_state();
		if (!aborted) begin
			test_idle_gate();
		end
		if (!aborted) begin
			upsp_checker_inst.start_test("full_frame");
			host_write(`UPSP_ADDR_UPSTR, 32'd1);
			run_frame(1'b0);
			poll_status();
			upsp_checker_inst.end_test();
		end
		if (!aborted) begin
			upsp_checker_inst.start_test("random_backpressure");
			restart_frame();
			run_frame(1'b1);
			upsp_checker_inst.end_test();
		end
		// Host polls while the last beats drain so its reads meet the status writes
		if (!aborted) begin
			upsp_checker_inst.start_test("status_contention");
			restart_frame();
			build_frame();
			fork
				send_frame(1'b1);
				drain_frame(1'b1);
				poll_near_end();
			join
			upsp_checker_inst.end_test();
		end
		if (!aborted) begin
			upsp_checker_inst.start_test("restart");
			restart_frame();
			host_read_check("UPSTR after restart", `UPSP_ADDR_UPSTR, 32'd1);
			host_read_check("UPENDR after restart", `UPSP_ADDR_UPENDR, 32'd0);
			run_frame(1'b1);
			poll_status();
			upsp_checker_inst.end_test();
		end

		upsp_checker_inst.print_counts();
		if (upsp_checker_inst.fail_cnt == 0 && !aborted) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
